//--- tb.f
rtl/ex_pkg.sv
rtl/ex_issue.sv
rtl/ex_alu.sv
rtl/ex_muldiv.sv
rtl/ex_lane.sv
rtl/ex_writeback.sv
rtl/ex_stage.sv
testbench/ex_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "All tests passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/ex_testdata.hex
// One lane per line, lane 0 then lane 1: ctrl rs1 rs2 pc imm exp_data exp_branch_pc
// ctrl hex digits: exp_taken exp_ldst op op sel_pc sel_imm compressed 0
00000000 00001234 00000fff 00000100 0000007f 00002233 00000000
00011100 deadbeef 12345678 00000200 00000010 000001f0 00000000
00020100 0000000f 00000003 00000104 00000024 000000f0 00000000
00070000 80000010 00000024 00000204 00000000 f8000001 00000000
00030000 ffffffff 00000001 00000108 00000000 00000001 00000000
00040000 ffffffff 00000001 00000208 00000000 00000000 00000000
00050100 0f0f0f0f 00000000 0000010c ffff0000 f0f00f0f 00000000
000a0100 12345678 00000000 0000020c abcde000 abcde000 00000000
100d1100 00000055 00000055 00001000 00000040 00000000 00001040
000e0100 00000055 00000055 00002000 fffffff0 00000000 00001ff0
100f0100 fffffff0 00000003 00001100 00000008 00000000 00001108
10120100 fffffff0 00000003 00002100 00000100 00000000 00002200
00110100 fffffff0 00000003 00001200 00000020 00000000 00001220
100b1110 00000000 00000000 00002300 00000102 00002302 00002402
100c0100 00004001 00000000 00001300 00000010 00001304 00004010
01130100 80000000 00000000 00002400 fffffffc 7ffffffc 00000000
01140100 00010000 cafef00d 00001400 00000123 00010123 00000000
00150000 00012345 00006789 00002500 00000000 75cca2ed 00000000
00160000 fffffffe 00000003 00001500 00000000 ffffffff 00000000
00170000 fffffffe 00000003 00002600 00000000 00000002 00000000
00180000 ffffff9c 00000007 00001600 00000000 fffffff2 00000000
00090000 ff00ff00 0f0f0f0f 00002700 00000000 0f000f00 00000000
001a0000 ffffff9c 00000007 00001700 00000000 fffffffe 00000000
00190000 ffffff9c 00000007 00002800 00000000 24924916 00000000
00180000 00001234 00000000 00001800 00000000 ffffffff 00000000
001b0000 87654321 00000000 00002900 00000000 87654321 00000000
00180000 80000000 ffffffff 00001900 00000000 80000000 00000000
001a0000 80000000 ffffffff 00002a00 00000000 00000000 00000000

//--- testbench/ex_stage_tb.sv
// Execute stage testbench with clock, reset, file-driven bundles, result checks and report.
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;
    import ex_pkg::*;

    localparam int NUM_LANES      = 2;
    localparam int NUM_BUNDLES    = 14;
    localparam int WORDS_PER_LANE = 7;
    localparam int NUM_WORDS      = NUM_BUNDLES * NUM_LANES * WORDS_PER_LANE;
    localparam int RESET_CYCLES   = 8;
    localparam int RESULT_LIMIT   = 40;
    localparam int TIMEOUT_CYCLES = NUM_BUNDLES * 40 + RESET_CYCLES;

    logic                       clk;
    logic                       arst_n;
    ex_issue_t  [NUM_LANES-1:0] issue;
    logic                       issue_valid;
    ex_result_t [NUM_LANES-1:0] result;
    logic                       result_valid;
    logic                       stall;

    logic [31:0] testdata [0:NUM_WORDS-1];
    int          error_count;
    int          check_count;
    int          cycle_count;

    ex_stage #(
        .NUM_LANES (NUM_LANES)
    ) ex_stage_i (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .issue_i        (issue),
        .issue_valid_i  (issue_valid),
        .result_o       (result),
        .result_valid_o (result_valid),
        .stall_o        (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Some tests failed");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    // Control word digits are taken, ldst, op (two digits), sel_pc, sel_imm, compressed.
    task automatic drive_bundle(input int b);
        int          base;
        logic [31:0] ctrl;
        for (int k = 0; k < NUM_LANES; k++) begin
            base = (b * NUM_LANES + k) * WORDS_PER_LANE;
            ctrl = testdata[base];
            issue[k].op         = alu_op_e'(ctrl[20:16]);
            issue[k].rs1_data   = testdata[base+1];
            issue[k].rs2_data   = testdata[base+2];
            issue[k].pc         = testdata[base+3];
            issue[k].imm        = testdata[base+4];
            issue[k].sel_pc     = ctrl[12];
            issue[k].sel_imm    = ctrl[8];
            issue[k].compressed = ctrl[4];
        end
        issue_valid = 1'b1;
    endtask

    function automatic logic has_divide(input int b);
        alu_op_e op;
        logic    found;
        found = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            op = alu_op_e'(testdata[(b * NUM_LANES + k) * WORDS_PER_LANE][20:16]);
            if (op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU}) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic check_lane(input int b, input int k);
        int    base;
        string where;
        base  = (b * NUM_LANES + k) * WORDS_PER_LANE;
        where = $sformatf("[%0d] in bundle %0d", k, b);
        compare({"result_o", where, " data"}, result[k].data, testdata[base+5]);
        compare({"result_o", where, " branch_taken"}, {31'd0, result[k].branch_taken},
                {31'd0, testdata[base][28]});
        compare({"result_o", where, " branch_pc"}, result[k].branch_pc, testdata[base+6]);
        compare({"result_o", where, " ldst"}, {31'd0, result[k].ldst},
                {31'd0, testdata[base][24]});
    endtask

    initial begin
        int   waited;
        logic div_bundle;
        logic stall_gap;
        arst_n      = 1'b0;
        issue       = '0;
        issue_valid = 1'b0;
        error_count = 0;
        check_count = 0;
        $readmemh("testbench/ex_testdata.hex", testdata);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        compare("stall_o after reset", {31'd0, stall}, 32'd0);
        compare("result_valid_o after reset", {31'd0, result_valid}, 32'd0);
        for (int k = 0; k < NUM_LANES; k++) begin
            compare($sformatf("result_o[%0d] data after reset", k), result[k].data, 32'd0);
            compare($sformatf("result_o[%0d] branch_pc after reset", k),
                    result[k].branch_pc, 32'd0);
            compare($sformatf("result_o[%0d] flags after reset", k),
                    {30'd0, result[k].branch_taken, result[k].ldst}, 32'd0);
        end

        drive_bundle(0);
        for (int b = 0; b < NUM_BUNDLES; b++) begin
            div_bundle = has_divide(b);
            @(negedge clk);
            // The next bundle is offered at once and must be held off while a divide runs.
            if (b + 1 < NUM_BUNDLES) begin
                drive_bundle(b + 1);
            end else begin
                issue_valid = 1'b0;
            end
            if (!div_bundle) begin
                if (!result_valid) begin
                    error_count++;
                    $display("Bundle %0d: result_valid_o did not pulse one cycle after issue", b);
                end
            end else begin
                waited    = 0;
                stall_gap = 1'b0;
                while (!result_valid && waited < RESULT_LIMIT) begin
                    if (!stall) begin
                        stall_gap = 1'b1;
                    end
                    @(negedge clk);
                    waited++;
                end
                if (stall_gap) begin
                    error_count++;
                    $display("Bundle %0d: stall_o went low while the divide was running", b);
                end
                if (!result_valid) begin
                    error_count++;
                    $display("Bundle %0d: result_valid_o never came after the divide", b);
                end
            end
            compare($sformatf("stall_o with result of bundle %0d", b), {31'd0, stall}, 32'd0);
            for (int k = 0; k < NUM_LANES; k++) begin
                check_lane(b, k);
            end
        end

        repeat (3) begin
            @(negedge clk);
            if (result_valid) begin
                error_count++;
                $display("result_valid_o pulsed with no bundle in flight");
            end
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
// Execute stage top level: issue, parallel lanes and writeback.
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
    parameter int NUM_LANES = 2
) (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  ex_pkg::ex_issue_t  [NUM_LANES-1:0] issue_i,
    input  logic                               issue_valid_i,
    output ex_pkg::ex_result_t [NUM_LANES-1:0] result_o,
    output logic                               result_valid_o,
    output logic                               stall_o
);
    import ex_pkg::*;

    ex_operand_t [NUM_LANES-1:0] operand;
    ex_result_t  [NUM_LANES-1:0] lane_result;
    logic        [NUM_LANES-1:0] needs_wait;
    logic        [NUM_LANES-1:0] busy;
    logic        [NUM_LANES-1:0] done;
    logic                        accept;

    // A bundle enters only while no divider runs.
    assign accept = issue_valid_i && !stall_o;

    ex_issue #(
        .NUM_LANES (NUM_LANES)
    ) ex_issue_i (
        .issue_i   (issue_i),
        .operand_o (operand)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        ex_lane ex_lane_i (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .start_i      (accept),
            .operand_i    (operand[k]),
            .result_o     (lane_result[k]),
            .needs_wait_o (needs_wait[k]),
            .busy_o       (busy[k]),
            .done_o       (done[k])
        );
    end

    ex_writeback #(
        .NUM_LANES (NUM_LANES)
    ) ex_writeback_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .accept_i       (accept),
        .result_i       (lane_result),
        .needs_wait_i   (needs_wait),
        .busy_i         (busy),
        .done_i         (done),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .stall_o        (stall_o)
    );

endmodule

`default_nettype wire

//--- rtl/ex_writeback.sv
// Writeback block: lane result registers, stall request and bundle-valid pulse.
`timescale 1ns/1ps
`default_nettype none

module ex_writeback #(
    parameter int NUM_LANES = 2
) (
    input  logic                               clk,
    input  logic                               arst_n_i,
    input  logic                               accept_i,
    input  ex_pkg::ex_result_t [NUM_LANES-1:0] result_i,
    input  logic [NUM_LANES-1:0]               needs_wait_i,
    input  logic [NUM_LANES-1:0]               busy_i,
    input  logic [NUM_LANES-1:0]               done_i,
    output ex_pkg::ex_result_t [NUM_LANES-1:0] result_o,
    output logic                               result_valid_o,
    output logic                               stall_o
);
    logic open_q;
    logic last_done;

    assign stall_o = |busy_i;

    // Busy and done coincide in a divider's final cycle.
    assign last_done = open_q && ((busy_i & ~done_i) == '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            open_q         <= 1'b0;
            result_valid_o <= 1'b0;
            result_o       <= '0;
        end else begin
            result_valid_o <= 1'b0;
            if (accept_i) begin
                open_q         <= |needs_wait_i;
                result_valid_o <= ~|needs_wait_i;
            end else if (last_done) begin
                open_q         <= 1'b0;
                result_valid_o <= 1'b1;
            end
            for (int k = 0; k < NUM_LANES; k++) begin
                if ((accept_i && !needs_wait_i[k]) || done_i[k]) begin
                    result_o[k] <= result_i[k];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n_i) !(result_valid_o && stall_o))
        else $error("result_valid_o raised while stalled");

endmodule

`default_nettype wire

//--- rtl/ex_lane.sv
// Execution lane: ALU and multiply/divide unit with result selection.
`timescale 1ns/1ps
`default_nettype none

module ex_lane (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                start_i,
    input  ex_pkg::ex_operand_t operand_i,
    output ex_pkg::ex_result_t  result_o,
    output logic                needs_wait_o,
    output logic                busy_o,
    output logic                done_o
);
    import ex_pkg::*;

    ex_result_t            alu_result;
    logic [DATA_WIDTH-1:0] md_data;
    logic                  is_m;

    ex_alu ex_alu_i (
        .operand_i (operand_i),
        .result_o  (alu_result)
    );

    ex_muldiv ex_muldiv_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (start_i),
        .operand_i (operand_i),
        .data_o    (md_data),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    assign needs_wait_o = is_div_op(operand_i.op);
    assign is_m         = needs_wait_o || operand_i.op inside {ALU_MUL, ALU_MULH, ALU_MULHU};

    always_comb begin
        result_o = alu_result;
        // A divide in flight owns the lane output, whatever the source now holds.
        if (busy_o) begin
            result_o      = '0;
            result_o.data = md_data;
        end else if (is_m) begin
            result_o.data = md_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ex_muldiv.sv
// Multiply/divide unit: single-cycle multiply and a 32-step restoring divider.
`timescale 1ns/1ps
`default_nettype none

module ex_muldiv (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          start_i,
    input  ex_pkg::ex_operand_t           operand_i,
    output logic [ex_pkg::DATA_WIDTH-1:0] data_o,
    output logic                          busy_o,
    output logic                          done_o
);
    import ex_pkg::*;

    localparam int W = DATA_WIDTH;

    logic [2*W-1:0] prod_uu;
    logic [2*W-1:0] prod_ss;
    logic           div_start;
    logic           is_signed;
    logic           a_neg;
    logic           b_neg;
    logic [W-1:0]   mag_a;
    logic [W-1:0]   mag_b;
    logic [W-1:0]   rem_in;
    logic [W-1:0]   quo_in;
    logic [W-1:0]   dvsr_in;
    logic [W:0]     rem_shift;
    logic [W:0]     diff;
    logic [W-1:0]   rem_q;
    logic [W-1:0]   quo_q;
    logic [W-1:0]   dvsr_q;
    logic [4:0]     cnt_q;
    logic           busy_q;
    logic           done_q;
    logic           neg_quo_q;
    logic           neg_rem_q;
    logic           want_rem_q;
    logic [W-1:0]   div_result;

    assign prod_uu = {{W{1'b0}}, operand_i.a} * {{W{1'b0}}, operand_i.b};
    assign prod_ss = {{W{operand_i.a[W-1]}}, operand_i.a} * {{W{operand_i.b[W-1]}}, operand_i.b};

    assign div_start = start_i && is_div_op(operand_i.op);
    assign is_signed = operand_i.op inside {ALU_DIV, ALU_REM};
    assign a_neg     = is_signed && operand_i.a[W-1];
    assign b_neg     = is_signed && operand_i.b[W-1];
    assign mag_a     = a_neg ? -operand_i.a : operand_i.a;
    assign mag_b     = b_neg ? -operand_i.b : operand_i.b;

    // The first step runs on the start edge straight from the operands.
    assign rem_in    = div_start ? '0 : rem_q;
    assign quo_in    = div_start ? mag_a : quo_q;
    assign dvsr_in   = div_start ? mag_b : dvsr_q;
    assign rem_shift = {rem_in, quo_in[W-1]};
    assign diff      = rem_shift - {1'b0, dvsr_in};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (div_start) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= 5'd31;
        end else if (done_q) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 5'd1;
            if (cnt_q == 5'd1) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            dvsr_q     <= mag_b;
            neg_quo_q  <= (a_neg ^ b_neg) && (operand_i.b != '0);
            neg_rem_q  <= a_neg;
            want_rem_q <= operand_i.op inside {ALU_REM, ALU_REMU};
        end
        if (div_start || (busy_q && !done_q)) begin
            rem_q <= diff[W] ? rem_shift[W-1:0] : diff[W-1:0];
            quo_q <= {quo_in[W-2:0], ~diff[W]};
        end
    end

    // Divide by zero and overflow fall out of the magnitude divider and the sign fix.
    assign div_result = want_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                                   : (neg_quo_q ? -quo_q : quo_q);

    always_comb begin
        if (busy_q) begin
            data_o = div_result;
        end else begin
            case (operand_i.op)
                ALU_MUL:   data_o = prod_uu[W-1:0];
                ALU_MULH:  data_o = prod_ss[2*W-1:W];
                ALU_MULHU: data_o = prod_uu[2*W-1:W];
                default:   data_o = div_result;
            endcase
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

    assert property (@(posedge clk) disable iff (!arst_n_i) start_i |-> !busy_o)
        else $error("start seen while the divider is busy");
    assert property (@(posedge clk) disable iff (!arst_n_i) done_o |=> !done_o)
        else $error("done held longer than one cycle");

endmodule

`default_nettype wire

//--- rtl/ex_alu.sv
// Integer ALU with arithmetic, logic, shifts, branch compare, jump targets and load/store address.
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::ex_operand_t operand_i,
    output ex_pkg::ex_result_t  result_o
);
    import ex_pkg::*;

    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] rs2;
    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] link;
    logic [4:0]            shamt;
    logic                  cmp_taken;

    assign a     = operand_i.a;
    assign b     = operand_i.b;
    assign rs2   = operand_i.rs2_data;
    assign sum   = a + b;
    assign shamt = b[4:0];
    // Link address skips a 16-bit or a 32-bit instruction.
    assign link  = operand_i.pc + (operand_i.compressed ? 32'd2 : 32'd4);

    always_comb begin
        case (operand_i.op)
            ALU_BEQ:  cmp_taken = (a == rs2);
            ALU_BNE:  cmp_taken = (a != rs2);
            ALU_BLT:  cmp_taken = ($signed(a) < $signed(rs2));
            ALU_BGE:  cmp_taken = ($signed(a) >= $signed(rs2));
            ALU_BLTU: cmp_taken = (a < rs2);
            ALU_BGEU: cmp_taken = (a >= rs2);
            default:  cmp_taken = 1'b0;
        endcase
    end

    always_comb begin
        result_o = '0;
        case (operand_i.op)
            ALU_ADD:  result_o.data = sum;
            ALU_SUB:  result_o.data = a - b;
            ALU_SLL:  result_o.data = a << shamt;
            ALU_SLT:  result_o.data = {{(DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result_o.data = {{(DATA_WIDTH-1){1'b0}}, a < b};
            ALU_XOR:  result_o.data = a ^ b;
            ALU_SRL:  result_o.data = a >> shamt;
            ALU_SRA:  result_o.data = $signed(a) >>> shamt;
            ALU_OR:   result_o.data = a | b;
            ALU_AND:  result_o.data = a & b;
            ALU_LUI:  result_o.data = b;
            ALU_JAL, ALU_JALR: begin
                result_o.data         = link;
                result_o.branch_taken = 1'b1;
                result_o.branch_pc    = {sum[DATA_WIDTH-1:1],
                                         sum[0] & (operand_i.op != ALU_JALR)};
            end
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
                result_o.branch_taken = cmp_taken;
                result_o.branch_pc    = operand_i.pc + b;
            end
            ALU_LOAD, ALU_STORE: begin
                result_o.data = sum;
                result_o.ldst = 1'b1;
            end
            // M operations are produced by the multiply/divide unit.
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_issue.sv
// Issue block: per-lane operand selection from the issue words of a bundle.
`timescale 1ns/1ps
`default_nettype none

module ex_issue #(
    parameter int NUM_LANES = 2
) (
    input  ex_pkg::ex_issue_t   [NUM_LANES-1:0] issue_i,
    output ex_pkg::ex_operand_t [NUM_LANES-1:0] operand_o
);
    import ex_pkg::*;

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            operand_o[k].op         = issue_i[k].op;
            operand_o[k].pc         = issue_i[k].pc;
            operand_o[k].rs2_data   = issue_i[k].rs2_data;
            operand_o[k].compressed = issue_i[k].compressed;

            // Branches always compare register values, so a stays on rs1.
            if (issue_i[k].sel_pc && !is_cond_branch(issue_i[k].op)) begin
                operand_o[k].a = issue_i[k].pc;
            end else begin
                operand_o[k].a = issue_i[k].rs1_data;
            end

            if (issue_i[k].sel_imm) begin
                operand_o[k].b = issue_i[k].imm;
            end else begin
                operand_o[k].b = issue_i[k].rs2_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ex_pkg.sv
// Execute stage package: data width, ALU operation codes, lane structs and op-class helpers.
`default_nettype none

package ex_pkg;

    localparam int DATA_WIDTH = 32;

    // Encoded from zero upward in the order listed.
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_LUI, ALU_JAL, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_LOAD, ALU_STORE, ALU_MUL, ALU_MULH, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef struct packed {
        alu_op_e               op;
        logic [DATA_WIDTH-1:0] rs1_data;
        logic [DATA_WIDTH-1:0] rs2_data;
        logic [DATA_WIDTH-1:0] pc;
        logic [DATA_WIDTH-1:0] imm;
        logic                  sel_pc;
        logic                  sel_imm;
        logic                  compressed;
    } ex_issue_t;

    typedef struct packed {
        alu_op_e               op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] rs2_data;
        logic [DATA_WIDTH-1:0] pc;
        logic                  compressed;
    } ex_operand_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  branch_taken;
        logic [DATA_WIDTH-1:0] branch_pc;
        logic                  ldst;
    } ex_result_t;

    function automatic logic is_cond_branch(alu_op_e op);
        return op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};
    endfunction

    function automatic logic is_div_op(alu_op_e op);
        return op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    endfunction

endpackage

`default_nettype wire
